/* hw/krz_boot_pkg.sv */
// ====================
// Shared sizes, SPI opcode, FSM encodings and the boot word type
// for the flash boot path
// ====================

package krz_boot_pkg;

    // ====================
    // Boot image layout
    // ====================

    // Image starts 1 MiB into the flash
    localparam logic [23:0] BOOT_BASE = 24'h10_0000;

    // 32-bit words in the image
    localparam int BOOT_WORDS = 64;
    localparam int RAM_ADDR_W = $clog2(BOOT_WORDS);

    // Loader queue depth, also the reader's starting credit count
    localparam int BOOT_CREDITS = 4;
    localparam int CREDIT_W     = $clog2(BOOT_CREDITS + 1);
    localparam int QPTR_W       = $clog2(BOOT_CREDITS);

    // ====================
    // SPI side
    // ====================

    // Plain read, no dummy cycles
    localparam logic [7:0] SPI_READ_CMD = 8'h03;

    // Counts bits inside one 32-bit shift window
    localparam int BIT_CNT_W = 5;

    // Reader FSM encodings
    localparam logic [2:0] ST_IDLE = 3'd0;
    localparam logic [2:0] ST_CMD  = 3'd1;
    localparam logic [2:0] ST_ADDR = 3'd2;
    localparam logic [2:0] ST_DATA = 3'd3;
    localparam logic [2:0] ST_STOP = 3'd4;

    // Lane 0 holds the first byte off the wire, so the word is little-endian
    typedef union packed {
        logic [3:0][7:0] bytes;
        logic [31:0]     word;
    } boot_word_t;

endpackage

/* hw/boot_word_if.sv */
// ====================
// Word channel from the flash reader to the loader, credit flow control
// ====================

`timescale 1ns/1ps

interface boot_word_if;
    import krz_boot_pkg::*;

    // One-cycle word strobe, only sent while the reader holds a credit
    logic       valid;
    boot_word_t data;
    // Marks the final image word
    logic       last;
    // One pulse returns one credit
    logic       credit;

    modport reader (
        output valid,
        output data,
        output last,
        input  credit
    );

    modport loader (
        input  valid,
        input  data,
        input  last,
        output credit
    );

endinterface

/* hw/spi_flash_reader.sv */
// ====================
// SPI master that issues one flash read at BOOT_BASE and streams the
// image out as words, pausing sclk whenever it runs out of credits
// ====================

`timescale 1ns/1ps

module spi_flash_reader (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start,
    output logic        busy,
    output logic        sclk,
    output logic        mosi,
    output logic        flash_cs,
    input  logic        miso,
    boot_word_if.reader out
);
    import krz_boot_pkg::*;

    logic [2:0]            state;
    logic [BIT_CNT_W-1:0]  bit_cnt;
    logic [31:0]           tx_shift;
    boot_word_t            rx_word;
    logic                  word_full;
    logic [RAM_ADDR_W-1:0] word_cnt;
    logic [CREDIT_W-1:0]   credits;
    logic                  launch;
    logic                  rx_edge;
    logic                  send;
    logic                  word_last;

    assign busy      = (state != ST_IDLE);
    assign launch    = (state == ST_IDLE) && start;
    assign word_last = (word_cnt == RAM_ADDR_W'(BOOT_WORDS - 1));

    // Rising sclk in the data phase, miso is captured on this edge
    assign rx_edge = (state == ST_DATA) && !sclk && !word_full;

    // A full word goes out in the low half of sclk, only with credit left
    assign send = (state == ST_DATA) && !sclk && word_full && (credits != '0);

    // ====================
    // Sequencer
    // ====================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            sclk      <= 1'b0;
            mosi      <= 1'b0;
            flash_cs  <= 1'b1;
            bit_cnt   <= '0;
            word_cnt  <= '0;
            word_full <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state     <= ST_CMD;
                        flash_cs  <= 1'b0;
                        mosi      <= SPI_READ_CMD[7];
                        bit_cnt   <= '0;
                        word_cnt  <= '0;
                        word_full <= 1'b0;
                    end
                end

                ST_CMD: begin
                    sclk <= !sclk;
                    // mosi only moves on the falling edge
                    if (sclk) begin
                        mosi    <= tx_shift[30];
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 5'd7) begin
                            state   <= ST_ADDR;
                            bit_cnt <= '0;
                        end
                    end
                end

                ST_ADDR: begin
                    sclk <= !sclk;
                    if (sclk) begin
                        mosi    <= tx_shift[30];
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 5'd23) begin
                            state   <= ST_DATA;
                            bit_cnt <= '0;
                            mosi    <= 1'b0;
                        end
                    end
                end

                ST_DATA: begin
                    if (sclk) begin
                        sclk <= 1'b0;
                    end else if (word_full) begin
                        // No credit means sclk just stays low here
                        if (send) begin
                            word_full <= 1'b0;
                            word_cnt  <= word_cnt + 1'b1;
                            if (word_last) begin
                                state    <= ST_STOP;
                                flash_cs <= 1'b1;
                            end
                        end
                    end else begin
                        sclk    <= 1'b1;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 5'd31) begin
                            word_full <= 1'b1;
                        end
                    end
                end

                ST_STOP: begin
                    // Stay busy until the loader has drained its queue
                    if (credits + CREDIT_W'(out.credit) == CREDIT_W'(BOOT_CREDITS)) begin
                        state <= ST_IDLE;
                    end
                end

                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // ====================
    // Shift registers
    // ====================

    always_ff @(posedge clk) begin
        if (launch) begin
            tx_shift <= {SPI_READ_CMD, BOOT_BASE};
        end else if ((state == ST_CMD || state == ST_ADDR) && sclk) begin
            tx_shift <= {tx_shift[30:0], 1'b0};
        end

        // MSB first within each byte, bytes fill lanes 0 to 3
        if (rx_edge) begin
            rx_word.bytes[bit_cnt[4:3]] <= {rx_word.bytes[bit_cnt[4:3]][6:0], miso};
        end

        if (send) begin
            out.data <= rx_word;
        end
    end

    // Credit counter and word strobes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits   <= '0;
            out.valid <= 1'b0;
            out.last  <= 1'b0;
        end else begin
            out.valid <= send;
            out.last  <= send && word_last;
            if (launch) begin
                credits <= CREDIT_W'(BOOT_CREDITS);
            end else begin
                credits <= credits + CREDIT_W'(out.credit) - CREDIT_W'(send);
            end
        end
    end

endmodule

/* hw/boot_loader.sv */
// ====================
// Queues incoming boot words and writes them into the boot RAM,
// one credit back per word written, done after the last one
// ====================

`timescale 1ns/1ps

module boot_loader (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                start,
    boot_word_if.loader                         in,
    output logic                                we,
    output logic [krz_boot_pkg::RAM_ADDR_W-1:0] waddr,
    output logic [31:0]                         wdata,
    output logic                                done
);
    import krz_boot_pkg::*;

    // Circular queue, one slot per credit
    boot_word_t          q_data [BOOT_CREDITS];
    logic                q_last [BOOT_CREDITS];
    logic [QPTR_W-1:0]   wr_ptr;
    logic [QPTR_W-1:0]   rd_ptr;
    logic [CREDIT_W-1:0] count;

    logic active;
    logic begin_boot;
    logic pop;
    logic push;

    // Start is only taken between boots
    assign begin_boot = start && !active;

    assign push = in.valid;
    // Drain one entry per cycle whenever something is queued
    assign pop  = (count != '0);

    assign we        = pop;
    assign wdata     = q_data[rd_ptr].word;
    assign in.credit = pop;

    // ====================
    // Queue storage
    // ====================

    always_ff @(posedge clk) begin
        if (push) begin
            q_data[wr_ptr] <= in.data;
            q_last[wr_ptr] <= in.last;
        end
    end

    // Pointers and fill level
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + CREDIT_W'(push) - CREDIT_W'(pop);
        end
    end

    // ====================
    // Write address and completion
    // ====================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            waddr  <= '0;
            done   <= 1'b0;
            active <= 1'b0;
        end else begin
            if (begin_boot) begin
                waddr  <= '0;
                done   <= 1'b0;
                active <= 1'b1;
            end else if (pop) begin
                waddr <= waddr + 1'b1;
                // Last word written this cycle, done shows next cycle
                if (q_last[rd_ptr]) begin
                    done   <= 1'b1;
                    active <= 1'b0;
                end
            end
        end
    end

endmodule

/* hw/boot_ram.sv */
// ====================
// Boot RAM with a loader write port and a one-cycle fetch read port
// ====================

`timescale 1ns/1ps

module boot_ram (
    input  logic                                clk,
    input  logic                                we,
    input  logic [krz_boot_pkg::RAM_ADDR_W-1:0] waddr,
    input  logic [31:0]                         wdata,
    input  logic [krz_boot_pkg::RAM_ADDR_W-1:0] rd_addr,
    output logic [31:0]                         rd_data
);
    import krz_boot_pkg::*;

    logic [31:0] mem [BOOT_WORDS];

    // ====================
    // Write port
    // ====================

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // ====================
    // Read port
    // ====================

    // Registered output, data follows the address by one cycle
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* hw/krz_boot_top.sv */
// ====================
// Flash boot subsystem top, SPI flash in, boot RAM fetch port and LEDs out
// ====================

`timescale 1ns/1ps

module krz_boot_top (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                start,
    input  logic                                miso,
    input  logic [krz_boot_pkg::RAM_ADDR_W-1:0] rd_addr,
    output logic                                sclk,
    output logic                                mosi,
    output logic                                flash_cs,
    output logic [31:0]                         rd_data,
    output logic                                led_busy,
    output logic                                led_done
);
    import krz_boot_pkg::*;

    // Loader to RAM write path
    logic                  ram_we;
    logic [RAM_ADDR_W-1:0] ram_waddr;
    logic [31:0]           ram_wdata;

    boot_word_if word_if ();

    // ====================
    // Flash side
    // ====================

    spi_flash_reader spi_flash_reader_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .busy     (led_busy),
        .sclk     (sclk),
        .mosi     (mosi),
        .flash_cs (flash_cs),
        .miso     (miso),
        .out      (word_if.reader)
    );

    boot_loader boot_loader_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .in    (word_if.loader),
        .we    (ram_we),
        .waddr (ram_waddr),
        .wdata (ram_wdata),
        .done  (led_done)
    );

    // ====================
    // Boot memory
    // ====================

    boot_ram boot_ram_inst (
        .clk     (clk),
        .we      (ram_we),
        .waddr   (ram_waddr),
        .wdata   (ram_wdata),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

/* bench/spi_flash_model.sv */
// ====================
// Behavioral SPI flash, plain 03h read served from a byte window at BOOT_BASE
// ====================

`timescale 1ns/1ps

module spi_flash_model (
    input  logic        flash_cs,
    input  logic        sclk,
    input  logic        mosi,
    output logic        miso,
    output logic [31:0] cmd_word,
    output logic        cmd_valid
);
    import krz_boot_pkg::*;

    localparam int WINDOW_BYTES = BOOT_WORDS * 4;

    // Image bytes, loaded by the testbench
    logic [7:0]  mem [WINDOW_BYTES];
    int unsigned rx_bits;
    int unsigned tx_bits;
    logic [23:0] rd_base;
    logic [7:0]  cur_byte;

    // Outside the window the flash reads as erased
    function automatic logic [7:0] read_byte(input logic [23:0] addr);
        logic [23:0] offset;
        offset = addr - BOOT_BASE;
        if (offset < WINDOW_BYTES) begin
            return mem[offset];
        end
        return 8'hff;
    endfunction

    initial begin
        miso      = 1'b0;
        cmd_word  = '0;
        cmd_valid = 1'b0;
        rx_bits   = 0;
        tx_bits   = 0;
        rd_base   = '0;
    end

    always @(negedge flash_cs) begin
        rx_bits   = 0;
        tx_bits   = 0;
        cmd_valid = 1'b0;
    end

    // Opcode and address, MSB first on rising sclk
    always @(posedge sclk) begin
        if (!flash_cs && rx_bits < 32) begin
            cmd_word = {cmd_word[30:0], mosi};
            rx_bits  = rx_bits + 1;
            if (rx_bits == 32) begin
                cmd_valid = 1'b1;
                rd_base   = cmd_word[23:0];
            end
        end
    end

    // Data shifts out on falling sclk, held while sclk is paused
    always @(negedge sclk) begin
        if (!flash_cs && cmd_valid) begin
            cur_byte = read_byte(rd_base + 24'(tx_bits / 8));
            miso     = cur_byte[7 - (tx_bits % 8)];
            tx_bits  = tx_bits + 1;
        end
    end

endmodule

/* bench/krz_boot_properties.sv */
// ====================
// SPI pin and credit protocol checks bound into the flash reader
// ====================

`timescale 1ns/1ps

module krz_boot_properties (
    input logic                              clk,
    input logic                              rst_n,
    input logic                              busy,
    input logic                              sclk,
    input logic                              mosi,
    input logic                              flash_cs,
    input logic                              valid,
    input logic [krz_boot_pkg::CREDIT_W-1:0] credits
);
    import krz_boot_pkg::*;

    int unsigned fail_cnt = 0;

    // Chip select stays high whenever the reader is idle
    cs_idle_high: assert property (@(posedge clk) disable iff (!rst_n) !busy |-> flash_cs)
        else begin
            $error("flash_cs low while the reader is idle");
            fail_cnt++;
        end

    // mosi only moves while sclk is low
    mosi_stable: assert property (@(posedge clk) disable iff (!rst_n) sclk |-> $stable(mosi))
        else begin
            $error("mosi changed while sclk was high");
            fail_cnt++;
        end

    // A word strobe needs a credit in the cycle it was launched
    valid_credit: assert property (@(posedge clk) disable iff (!rst_n)
        valid |-> $past(credits) != '0)
        else begin
            $error("word sent with no credit left");
            fail_cnt++;
        end

    credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        credits <= CREDIT_W'(BOOT_CREDITS))
        else begin
            $error("credit count above the queue depth");
            fail_cnt++;
        end

endmodule

bind spi_flash_reader krz_boot_properties properties_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .busy     (busy),
    .sclk     (sclk),
    .mosi     (mosi),
    .flash_cs (flash_cs),
    .valid    (out.valid),
    .credits  (credits)
);

/* bench/tb_krz_boot.sv */
// ====================
// Testbench for the flash boot top with random images and a word model
// ====================

`timescale 1ns/1ps

module tb_krz_boot;
    import krz_boot_pkg::*;

    // Five boots worth of SPI bit time plus slack for reads and resets
    localparam int BOOT_CYCLES    = (32 + 32 * BOOT_WORDS) * 2;
    localparam int TIMEOUT_CYCLES = 5 * BOOT_CYCLES + 2000;

    logic                  clk;
    logic                  rst_n;
    logic                  start;
    logic                  miso;
    logic [RAM_ADDR_W-1:0] rd_addr;
    logic                  sclk;
    logic                  mosi;
    logic                  flash_cs;
    logic [31:0]           rd_data;
    logic                  led_busy;
    logic                  led_done;
    logic [31:0]           cmd_word;
    logic                  cmd_valid;

    int          seed      = 32'h583829a9;
    int          checks    = 0;
    int          errors    = 0;
    int          prop_seen = 0;
    int          cycle_cnt = 0;
    logic [31:0] ref_words [BOOT_WORDS];

    krz_boot_top krz_boot_top_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .miso     (miso),
        .rd_addr  (rd_addr),
        .sclk     (sclk),
        .mosi     (mosi),
        .flash_cs (flash_cs),
        .rd_data  (rd_data),
        .led_busy (led_busy),
        .led_done (led_done)
    );

    spi_flash_model flash_model_inst (
        .flash_cs  (flash_cs),
        .sclk      (sclk),
        .mosi      (mosi),
        .miso      (miso),
        .cmd_word  (cmd_word),
        .cmd_valid (cmd_valid)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the boot sequence never finished", cycle_cnt);
            $display("test failed");
            $finish;
        end
    end

    // ====================
    // Helpers
    // ====================

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    // Fresh random image with reference words packed little-endian
    task automatic load_image();
        logic [7:0] b;
        for (int i = 0; i < BOOT_WORDS * 4; i++) begin
            b = 8'($random(seed));
            flash_model_inst.mem[i] = b;
            ref_words[i / 4][8 * (i % 4) +: 8] = b;
        end
    endtask

    task automatic pulse_start();
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        check_value("led_busy", led_busy, 32'd1);
        check_value("led_done", led_done, 32'd0);
    endtask

    task automatic check_cmd();
        while (!cmd_valid) @(negedge clk);
        check_value("cmd_word", cmd_word, {SPI_READ_CMD, BOOT_BASE});
    endtask

    task automatic wait_done();
        while (!led_done) @(negedge clk);
        check_value("led_busy", led_busy, 32'd0);
    endtask

    // Data follows the address one falling edge later
    task automatic check_ram();
        for (int a = 0; a < BOOT_WORDS; a++) begin
            rd_addr = RAM_ADDR_W'(a);
            @(negedge clk);
            check_value($sformatf("rd_data[%0d]", a), rd_data, ref_words[a]);
        end
    endtask

    task automatic report_test(input string name, input int err_mark);
        int prop_fails;
        prop_fails = krz_boot_top_inst.spi_flash_reader_inst.properties_inst.fail_cnt;
        errors += prop_fails - prop_seen;
        prop_seen = prop_fails;
        $display("%-12s %s, %0d errors", name, (errors == err_mark) ? "ok" : "FAIL",
                 errors - err_mark);
    endtask

    // ====================
    // Test sequence
    // ====================

    initial begin
        int err_mark;
        int hold;
        rst_n   = 1'b0;
        start   = 1'b0;
        rd_addr = '0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        err_mark = errors;
        @(negedge clk);
        check_value("flash_cs", flash_cs, 32'd1);
        check_value("sclk", sclk, 32'd0);
        check_value("mosi", mosi, 32'd0);
        check_value("led_busy", led_busy, 32'd0);
        check_value("led_done", led_done, 32'd0);
        report_test("reset_state", err_mark);

        err_mark = errors;
        load_image();
        pulse_start();
        check_cmd();
        report_test("command", err_mark);

        err_mark = errors;
        wait_done();
        check_ram();
        report_test("boot_load", err_mark);

        err_mark = errors;
        load_image();
        pulse_start();
        check_cmd();
        wait_done();
        check_ram();
        report_test("reboot", err_mark);

        // Cut a boot short somewhere in the data phase
        err_mark = errors;
        load_image();
        pulse_start();
        hold = 100 + int'($unsigned($random(seed)) % 3000);
        repeat (hold) @(negedge clk);
        check_value("led_busy", led_busy, 32'd1);
        rst_n = 1'b0;
        @(negedge clk);
        check_value("flash_cs", flash_cs, 32'd1);
        check_value("sclk", sclk, 32'd0);
        check_value("led_done", led_done, 32'd0);
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        load_image();
        pulse_start();
        check_cmd();
        wait_done();
        check_ram();
        report_test("reset_mid", err_mark);

        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* compile.f */
hw/krz_boot_pkg.sv
hw/boot_word_if.sv
hw/spi_flash_reader.sv
hw/boot_loader.sv
hw/boot_ram.sv
hw/krz_boot_top.sv
bench/spi_flash_model.sv
bench/krz_boot_properties.sv
bench/tb_krz_boot.sv

/* Bender.yml */
package:
  name: krz_boot

sources:
  - hw/krz_boot_pkg.sv
  - hw/boot_word_if.sv
  - hw/spi_flash_reader.sv
  - hw/boot_loader.sv
  - hw/boot_ram.sv
  - hw/krz_boot_top.sv
  - target: test
    files:
      - bench/spi_flash_model.sv
      - bench/krz_boot_properties.sv
      - bench/tb_krz_boot.sv
